// ==== common/corePkg.sv ====
/* Core-internal types: register indices, immediate select and the
   control bundle. Write fields of the bundle arrive already condition gated. */
package corePkg;

   import isaPkg::*;

   localparam int regCount = 15;                // R0..R14 stored, R15 is the PC

   localparam logic [wordWidth-1:0] resetPc = '0;
   localparam logic [wordWidth-1:0] pcStep  = 4;

   typedef logic [3:0] regAddr;

   localparam regAddr pcReg = 4'd15;

   typedef enum logic [1:0] {
      imm8,                                     // Data processing
      imm12,                                    // LDR/STR offset
      branch24                                  // B offset
   } immSel;

   // Controller to datapath, 14 bits
   typedef struct packed {
      logic       readPcAsA;                    // Port A reads R15
      logic       readRdAsB;                    // Port B reads rd, STR data
      immSel      immSrc;
      logic       aluSrcImm;                    // srcB from extImm
      aluOp       aluCtrl;
      logic       memToReg;                     // Result from readData
      logic       regWrite;
      logic       memWrite;
      logic       pcSrc;                        // Jump to result
      logic [1:0] flagWrite;                    // [1] NZ, [0] CV
   } ctrlBundle;

endpackage

// ==== common/isaPkg.sv ====
/* Instruction word views, field encodings and ALU types of the ARMv4 subset.
   Only op values 0..2 and the five listed commands are decoded by the core. */
package isaPkg;

   localparam int wordWidth = 32;               // Data and address width

   // Data-processing command field
   localparam logic [3:0] cmdAnd = 4'b0000;
   localparam logic [3:0] cmdEor = 4'b0001;
   localparam logic [3:0] cmdSub = 4'b0010;
   localparam logic [3:0] cmdAdd = 4'b0100;
   localparam logic [3:0] cmdOrr = 4'b1100;

   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01,
      branch   = 2'b10                          // 2'b11 unused
   } opKind;

   typedef enum logic [3:0] {
      condEq = 4'b0000,                         // Z
      condNe = 4'b0001,                         // !Z
      condCs = 4'b0010,                         // C
      condCc = 4'b0011,
      condMi = 4'b0100,                         // N
      condPl = 4'b0101,
      condVs = 4'b0110,                         // V
      condVc = 4'b0111,
      condHi = 4'b1000,                         // C and !Z
      condLs = 4'b1001,
      condGe = 4'b1010,                         // N == V
      condLt = 4'b1011,
      condGt = 4'b1100,
      condLe = 4'b1101,
      condAl = 4'b1110
   } condCode;

   typedef enum logic [2:0] {
      add,
      sub,
      bitAnd,
      bitOr,
      bitXor
   } aluOp;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } aluFlags;

   typedef struct packed {
      logic       immediate;                    // I bit, always 0 for LDR/STR
      logic [3:0] cmd;
      logic       sBit;                         // S for data processing, L for memory
   } dpFunct;

   // Data-processing and load/store layout
   typedef struct packed {
      condCode    cond;
      opKind      op;
      dpFunct     funct;
      logic [3:0] rn;
      logic [3:0] rd;
      logic [11:0] operand;                     // imm8, {rm} or imm12
   } dpMemFormat;

   typedef struct packed {
      condCode     cond;
      opKind       op;
      logic [1:0]  funct;                       // Link bit ignored
      logic [23:0] offset;                      // Word offset, signed
   } branchFormat;

   typedef union packed {
      dpMemFormat  dp;
      branchFormat br;
   } instrWord;

endpackage

// ==== hw/armCore.sv ====
/* Single-cycle ARMv4 subset core, one instruction per clock.
   Instruction and data memories must answer combinationally.
   Register contents are undefined until written. */
`timescale 1ns/1ps

module armCore
   import isaPkg::*, corePkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  instrWord             instr,
   output logic [wordWidth-1:0] pc,
   output logic                 memWrite,
   output logic [wordWidth-1:0] dataAdr,
   output logic [wordWidth-1:0] writeData,
   input  logic [wordWidth-1:0] readData
);

   ctrlBundle            ctrl;
   aluFlags              flags;
   regAddr               readAddrA;
   regAddr               readAddrB;
   logic [wordWidth-1:0] pcPlus8;
   logic [wordWidth-1:0] srcA;
   logic [wordWidth-1:0] srcB;
   logic [wordWidth-1:0] extImm;
   logic [wordWidth-1:0] aluResult;
   logic [wordWidth-1:0] result;

   // Register addresses
   assign readAddrA = ctrl.readPcAsA ? pcReg : instr.dp.rn;
   assign readAddrB = ctrl.readRdAsB ? instr.dp.rd : instr.dp.operand[3:0];   // rd or rm

   assign srcB   = ctrl.aluSrcImm ? extImm : writeData;
   assign result = ctrl.memToReg ? readData : aluResult;   // LDR data or ALU

   assign dataAdr  = aluResult;
   assign memWrite = ctrl.memWrite;

   controller ctrlUnit (.clk(clk), .reset(reset), .instr(instr),
                        .aluFlagsIn(flags), .ctrl(ctrl));

   pcUnit pcGen (.clk(clk), .reset(reset), .pcSrc(ctrl.pcSrc),
                 .target(result), .pc(pc), .pcPlus8(pcPlus8));

   regFile regs (.clk(clk), .writeEn(ctrl.regWrite),
                 .readAddrA(readAddrA), .readAddrB(readAddrB),
                 .writeAddr(instr.dp.rd), .writeData(result),
                 .pcPlus8(pcPlus8), .readA(srcA), .readB(writeData));

   immExtend immGen (.instr(instr), .immSrc(ctrl.immSrc), .extImm(extImm));

   alu aluUnit (.srcA(srcA), .srcB(srcB), .aluCtrl(ctrl.aluCtrl),
                .result(aluResult), .flags(flags));

endmodule

// ==== hw/controller/controller.sv ====
/* Decode, NZCV register and condition check of the core.
   Unsupported opcodes decode to no writes; op 3 is flagged by an assertion.
   Only data-processing writes to R15 are turned into jumps. */
`timescale 1ns/1ps

module controller
   import isaPkg::*, corePkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  instrWord  instr,
   input  aluFlags   aluFlagsIn,
   output ctrlBundle ctrl
);

   ctrlBundle dec;                              // Ungated decode
   aluFlags   flags;                            // Committed NZCV
   logic      condEx;
   logic      ge;

   // Main and ALU decode
   always_comb
   begin
      dec = '0;
      unique case (instr.dp.op)
         dataProc:
         begin
            dec.immSrc    = imm8;
            dec.aluSrcImm = instr.dp.funct.immediate;
            dec.regWrite  = 1'b1;
            case (instr.dp.funct.cmd)
               cmdAnd:  dec.aluCtrl = bitAnd;
               cmdEor:  dec.aluCtrl = bitXor;
               cmdSub:  dec.aluCtrl = sub;
               cmdAdd:  dec.aluCtrl = add;
               cmdOrr:  dec.aluCtrl = bitOr;
               default: dec.aluCtrl = add;      // Not supported
            endcase
            dec.flagWrite[1] = instr.dp.funct.sBit;
            // C and V only for the adder ops
            dec.flagWrite[0] = instr.dp.funct.sBit &&
                               (instr.dp.funct.cmd == cmdAdd ||
                                instr.dp.funct.cmd == cmdSub);
            if (instr.dp.rd == pcReg)
            begin
               dec.pcSrc    = 1'b1;             // Result becomes next PC
               dec.regWrite = 1'b0;
            end
         end
         memory:
         begin
            dec.immSrc    = imm12;
            dec.aluSrcImm = 1'b1;               // rn + offset
            dec.aluCtrl   = add;
            dec.memToReg  = instr.dp.funct.sBit;
            dec.regWrite  = instr.dp.funct.sBit;   // LDR
            dec.memWrite  = !instr.dp.funct.sBit;  // STR
            dec.readRdAsB = !instr.dp.funct.sBit;
         end
         branch:
         begin
            dec.readPcAsA = 1'b1;               // PC+8 plus offset
            dec.immSrc    = branch24;
            dec.aluSrcImm = 1'b1;
            dec.aluCtrl   = add;
            dec.pcSrc     = 1'b1;
         end
         default: dec = '0;
      endcase
   end

   assign ge = (flags.neg == flags.overflow);

   always_comb
   begin
      case (instr.dp.cond)
         condEq:  condEx = flags.zero;
         condNe:  condEx = !flags.zero;
         condCs:  condEx = flags.carry;
         condCc:  condEx = !flags.carry;
         condMi:  condEx = flags.neg;
         condPl:  condEx = !flags.neg;
         condVs:  condEx = flags.overflow;
         condVc:  condEx = !flags.overflow;
         condHi:  condEx = flags.carry && !flags.zero;
         condLs:  condEx = !flags.carry || flags.zero;
         condGe:  condEx = ge;
         condLt:  condEx = !ge;
         condGt:  condEx = ge && !flags.zero;
         condLe:  condEx = !ge || flags.zero;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;                // Cond 1111 never executes
      endcase
   end

   // Every write is gated here
   always_comb
   begin
      ctrl           = dec;
      ctrl.regWrite  = dec.regWrite && condEx;
      ctrl.memWrite  = dec.memWrite && condEx;
      ctrl.pcSrc     = dec.pcSrc && condEx;
      ctrl.flagWrite = dec.flagWrite & {2{condEx}};
   end

   // Two-part flag register
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (ctrl.flagWrite[1])
            {flags.neg, flags.zero} <= {aluFlagsIn.neg, aluFlagsIn.zero};
         if (ctrl.flagWrite[0])
            {flags.carry, flags.overflow} <= {aluFlagsIn.carry, aluFlagsIn.overflow};
      end
   end

   opSupported: assert property (@(posedge clk) disable iff (reset)
      instr.dp.op != 2'b11);

   // Result mux carries either a load or a store address, never both
   oneWritePort: assert property (@(posedge clk) disable iff (reset)
      !(ctrl.memWrite && ctrl.regWrite));

endmodule

// ==== hw/datapath/alu.sv ====
/* Add, subtract and three bitwise ops with NZCV output.
   C and V read 0 for the logic ops; the controller never commits them there. */
`timescale 1ns/1ps

module alu
   import isaPkg::*;
(
   input  logic [wordWidth-1:0] srcA,
   input  logic [wordWidth-1:0] srcB,
   input  aluOp                 aluCtrl,
   output logic [wordWidth-1:0] result,
   output aluFlags              flags
);

   localparam int msb = wordWidth - 1;

   logic                 isSub;
   logic                 isArith;
   logic [wordWidth-1:0] bOperand;
   logic [wordWidth:0]   sum;                   // Extra bit is carry out

   assign isSub    = (aluCtrl == sub);
   assign isArith  = (aluCtrl == add) || isSub;
   assign bOperand = isSub ? ~srcB : srcB;      // A + ~B + 1
   assign sum      = {1'b0, srcA} + {1'b0, bOperand} + {{wordWidth{1'b0}}, isSub};

   always_comb
   begin
      case (aluCtrl)
         add,
         sub:     result = sum[msb:0];
         bitAnd:  result = srcA & srcB;
         bitOr:   result = srcA | srcB;
         bitXor:  result = srcA ^ srcB;
         default: result = '0;
      endcase
   end

   assign flags.neg   = result[msb];
   assign flags.zero  = ~|result;
   assign flags.carry = isArith && sum[wordWidth];   // Not-borrow on SUB
   // Operands agree in sign, result does not
   assign flags.overflow = isArith &&
                           !(srcA[msb] ^ srcB[msb] ^ isSub) &&
                           (srcA[msb] ^ sum[msb]);

   always_comb
   begin
      // Difference is zero only for equal operands
      if (isSub)
         zeroMatches: assert final (flags.zero == (srcA == srcB));
   end

endmodule

// ==== hw/datapath/immExtend.sv ====
/* Immediate extension for data processing, load/store and branch.
   imm8 and imm12 are zero extended; no rotate field is honored. */
`timescale 1ns/1ps

module immExtend
   import isaPkg::*, corePkg::*;
(
   input  instrWord             instr,
   input  immSel                immSrc,
   output logic [wordWidth-1:0] extImm
);

   always_comb
   begin
      case (immSrc)
         imm8:     extImm = {24'b0, instr.dp.operand[7:0]};
         imm12:    extImm = {20'b0, instr.dp.operand};
         // Word offset to byte offset
         branch24: extImm = {{6{instr.br.offset[23]}}, instr.br.offset, 2'b00};
         default:  extImm = '0;
      endcase
   end

endmodule

// ==== hw/datapath/pcUnit.sv ====
/* Program counter, advances every clock with no stall.
   A jump target must be word aligned. */
`timescale 1ns/1ps

module pcUnit
   import isaPkg::*, corePkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 pcSrc,
   input  logic [wordWidth-1:0] target,
   output logic [wordWidth-1:0] pc,
   output logic [wordWidth-1:0] pcPlus8
);

   logic [wordWidth-1:0] pcPlus4;
   logic [wordWidth-1:0] nextPc;

   assign pcPlus4 = pc + pcStep;
   assign pcPlus8 = pcPlus4 + pcStep;           // R15 as read by software
   assign nextPc  = pcSrc ? target : pcPlus4;   // Branch or rd 15 write

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= resetPc;
      else
         pc <= nextPc;
   end

   // Targets come from the ALU or data memory
   pcAligned: assert property (@(posedge clk) disable iff (reset)
      pc[1:0] == 2'b00);

endmodule

// ==== hw/datapath/regFile.sv ====
/* Fifteen registers, two combinational reads, one write per clock edge.
   Index 15 reads as PC+8 and must never be written here. No reset. */
`timescale 1ns/1ps

module regFile
   import isaPkg::*, corePkg::*;
(
   input  logic                 clk,
   input  logic                 writeEn,
   input  regAddr               readAddrA,
   input  regAddr               readAddrB,
   input  regAddr               writeAddr,
   input  logic [wordWidth-1:0] writeData,
   input  logic [wordWidth-1:0] pcPlus8,
   output logic [wordWidth-1:0] readA,
   output logic [wordWidth-1:0] readB
);

   logic [wordWidth-1:0] regs [regCount];       // R0..R14

   always_ff @(posedge clk)
   begin
      if (writeEn)
         regs[writeAddr] <= writeData;          // Visible next cycle
   end

   // R15 bypasses the array
   always_comb
   begin
      if (readAddrA == pcReg)
         readA = pcPlus8;
      else
         readA = regs[readAddrA];
      if (readAddrB == pcReg)
         readB = pcPlus8;                       // STR of R15
      else
         readB = regs[readAddrB];
   end

   // Controller turns rd 15 writes into jumps
   noPcWrite: assert property (@(posedge clk)
      writeEn |-> writeAddr != pcReg);

endmodule

// ==== list.f ====
common/isaPkg.sv
common/corePkg.sv
hw/controller/controller.sv
hw/datapath/regFile.sv
hw/datapath/alu.sv
hw/datapath/immExtend.sv
hw/datapath/pcUnit.sv
hw/armCore.sv
sim/armCoreTb.sv

// ==== sim/armCoreTb.sv ====
/* Self-checking testbench for armCore against a behavioral model of the core.
   R0 is cleared early and stays the only load/store base, and random code never
   writes R0 or R15. */
`timescale 1ns/1ps

module armCoreTb
   import isaPkg::*;
();

   localparam int maxCycles = 400;                 // End-of-program timeout

   // What the model expects from the current instruction
   typedef struct packed {
      logic        memWrite;
      logic [31:0] adr;
      logic [31:0] data;
      logic [31:0] nextPc;
      logic        regWrite;
      logic [31:0] regVal;
      aluFlags     flags;                          // Flags after this cycle
   } expectation;

   logic        clk;
   logic        reset;
   instrWord    instr;
   logic [31:0] pc;
   logic [31:0] dataAdr;
   logic [31:0] writeData;
   logic [31:0] readData;
   logic        memWrite;

   logic [31:0] imem [256];
   logic [31:0] dmem [64];
   logic [31:0] refMem [64];                       // Model copy of data memory
   logic [31:0] refRegs [16];                      // Entry 15 unused
   logic [31:0] refPc;
   aluFlags     refFlags;
   expectation  want;
   logic [31:0] rng;
   int          progLen;
   int          endIdx;

   armCore uut (.clk(clk), .reset(reset), .instr(instr), .pc(pc), .memWrite(memWrite),
                .dataAdr(dataAdr), .writeData(writeData), .readData(readData));

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Even codes test a flag term, odd codes invert it
   function automatic logic condHolds(input logic [3:0] cond, input aluFlags f);
      logic base;
      case (cond[3:1])
         3'd0:    base = f.zero;
         3'd1:    base = f.carry;
         3'd2:    base = f.neg;
         3'd3:    base = f.overflow;
         3'd4:    base = f.carry && !f.zero;
         3'd5:    base = (f.neg == f.overflow);
         3'd6:    base = (f.neg == f.overflow) && !f.zero;
         default: base = 1'b1;
      endcase
      if (cond[3:1] == 3'd7)
         return !cond[0];                          // AL runs, 1111 never
      return base ^ cond[0];
   endfunction

   function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic [3:0] cmd,
                                          input logic imm, input logic s, input logic [3:0] rn,
                                          input logic [3:0] rd, input logic [11:0] operand);
      return {cond, 2'b00, imm, cmd, s, rn, rd, operand};
   endfunction

   // Pre-indexed, offset added, word access
   function automatic logic [31:0] memWord(input logic [3:0] cond, input logic load,
                                           input logic [3:0] rn, input logic [3:0] rd,
                                           input logic [11:0] offset);
      return {cond, 2'b01, 5'b01100, load, rn, rd, offset};
   endfunction

   function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [23:0] offset);
      return {cond, 2'b10, 2'b10, offset};
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[progLen] = word;
      progLen++;
   endtask

   task automatic flagSweep(input logic [31:0] flagOp);
      emit(flagOp);
      emit(dpWord(condAl, cmdAdd, 1'b1, 1'b0, 4'd13, 4'd13, 12'd1));   // Non-S, flags hold
      for (int c = 0; c < 15; c++)
         emit(memWord(4'(c), 1'b0, 4'd0, 4'd2, 12'(c * 4)));
   endtask

   task automatic buildProgram();
      logic [3:0]  cmds [5];
      logic [3:0]  cond;
      logic [31:0] skipped;
      int          rdSel;
      cmds    = '{cmdAnd, cmdEor, cmdSub, cmdAdd, cmdOrr};
      skipped = dpWord(condAl, cmdAdd, 1'b1, 1'b0, 4'd0, 4'd0, 12'd1);   // Breaks R0 if run
      for (int i = 0; i < 256; i++)
         imem[i] = 32'h0;
      progLen = 0;
      emit(branchWord(condEq, 24'd1));              // Flags clear after reset, not taken
      for (int r = 1; r < 15; r++)
      begin
         rng = xorshift(rng);
         emit(dpWord(condAl, cmdAdd, 1'b1, 1'b0, 4'd15, 4'(r), {4'd0, rng[7:0]}));
      end
      emit(dpWord(condAl, cmdSub, 1'b0, 1'b0, 4'd15, 4'd0, 12'd15));   // R0 = 0
      emit(dpWord(condAl, cmdSub, 1'b0, 1'b0, 4'd15, 4'd6, 12'd15));   // R6 = 0
      emit(memWord(condAl, 1'b0, 4'd0, 4'd15, 12'd4));                  // STR of PC+8
      emit(dpWord(condAl, cmdAdd, 1'b1, 1'b0, 4'd15, 4'd15, 12'd4));   // Jump over two
      emit(skipped);
      emit(skipped);
      emit(branchWord(condAl, 24'd1));              // Forward to the backward branch
      emit(branchWord(condAl, 24'd2));              // Forward out of the block
      emit(skipped);
      emit(branchWord(condAl, 24'hfffffc));         // Back by two words
      emit(skipped);
      for (int k = 0; k < 5; k++)
      begin
         emit(dpWord(condAl, cmds[k], 1'b1, 1'b0, 4'd3, 4'd5, 12'h0a7));
         emit(memWord(condAl, 1'b0, 4'd0, 4'd5, 12'd8));
         emit(dpWord(condAl, cmds[k], 1'b0, 1'b0, 4'd3, 4'd5, 12'd4));   // rm = R4
         emit(memWord(condAl, 1'b0, 4'd0, 4'd5, 12'd8));
      end
      flagSweep(dpWord(condAl, cmdSub, 1'b0, 1'b1, 4'd2, 4'd1, 12'd2));    // Z and C
      flagSweep(dpWord(condAl, cmdSub, 1'b1, 1'b1, 4'd6, 4'd7, 12'd1));    // 0 - 1, borrow
      emit(memWord(condAl, 1'b1, 4'd0, 4'd9, 12'h080));                    // Word just below 2^31
      flagSweep(dpWord(condAl, cmdAdd, 1'b1, 1'b1, 4'd9, 4'd10, 12'h020)); // Signed overflow
      emit(dpWord(condAl, cmdSub, 1'b1, 1'b1, 4'd10, 4'd11, 12'h020));     // C and V both set
      flagSweep(dpWord(condAl, cmdAnd, 1'b1, 1'b1, 4'd11, 4'd12, 12'd0));  // CV must persist
      flagSweep(dpWord(condAl, cmdOrr, 1'b1, 1'b1, 4'd7, 4'd12, 12'd0));
      for (int n = 0; n < 40; n++)
      begin
         rng   = xorshift(rng);
         cond  = (rng[5:2] == 4'hf) ? condAl : rng[5:2];
         rdSel = 1 + int'(rng[19:16]) % 14;        // Never R0 or R15
         case (rng[1:0])
            2'd2:    emit(memWord(cond, 1'b0, 4'd0, rng[15:12], {4'd0, rng[25:20], 2'b00}));
            2'd3:    emit(memWord(cond, 1'b1, 4'd0, 4'(rdSel), {4'd0, rng[25:20], 2'b00}));
            default: emit(dpWord(cond, cmds[int'(rng[8:6]) % 5], rng[9], rng[10], rng[14:11],
                                 4'(rdSel), rng[9] ? {4'd0, rng[27:20]} : {8'd0, rng[31:28]}));
         endcase
      end
      endIdx = progLen;
      emit(branchWord(condAl, 24'hfffffe));         // Branch to self
   endtask

   task automatic failRun();
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
      failRun();
   endtask

   // Reference model, one instruction per cycle
   always_comb
   begin : model
      logic [31:0] srcN;
      logic [31:0] srcM;
      logic [31:0] srcD;
      logic [31:0] b;
      logic [31:0] res;
      logic [32:0] wide;
      logic        pass;
      logic        carry;
      logic        ovf;
      srcN  = (instr.dp.rn == 4'd15) ? refPc + 8 : refRegs[instr.dp.rn];
      srcM  = (instr.dp.operand[3:0] == 4'd15) ? refPc + 8 : refRegs[instr.dp.operand[3:0]];
      srcD  = (instr.dp.rd == 4'd15) ? refPc + 8 : refRegs[instr.dp.rd];
      b     = instr.dp.funct.immediate ? {24'b0, instr.dp.operand[7:0]} : srcM;
      res   = '0;
      wide  = '0;
      carry = 1'b0;
      ovf   = 1'b0;
      pass  = condHolds(instr.dp.cond, refFlags);
      want        = '0;
      want.nextPc = refPc + 4;
      want.flags  = refFlags;
      case (instr.dp.op)
         dataProc:
         begin
            case (instr.dp.funct.cmd)
               cmdAdd:
               begin
                  wide  = {1'b0, srcN} + {1'b0, b};
                  res   = wide[31:0];
                  carry = wide[32];
                  ovf   = (srcN[31] == b[31]) && (res[31] != srcN[31]);
               end
               cmdSub:
               begin
                  res   = srcN - b;
                  carry = (srcN >= b);             // Carry means no borrow
                  ovf   = (srcN[31] != b[31]) && (res[31] != srcN[31]);
               end
               cmdAnd:  res = srcN & b;
               cmdOrr:  res = srcN | b;
               default: res = srcN ^ b;
            endcase
            if (pass && instr.dp.funct.sBit)
            begin
               want.flags.neg  = res[31];
               want.flags.zero = (res == 32'd0);
               if (instr.dp.funct.cmd == cmdAdd || instr.dp.funct.cmd == cmdSub)
               begin
                  want.flags.carry    = carry;
                  want.flags.overflow = ovf;
               end
            end
            if (pass && instr.dp.rd == 4'd15)
               want.nextPc = res;                  // Write to R15 jumps
            else
            begin
               want.regWrite = pass;
               want.regVal   = res;
            end
         end
         memory:
         begin
            want.adr = srcN + {20'b0, instr.dp.operand};
            if (instr.dp.funct.sBit)
            begin
               want.regWrite = pass;
               want.regVal   = refMem[want.adr[7:2]];
            end
            else
            begin
               want.memWrite = pass;
               want.data     = srcD;
            end
         end
         branch:
            if (pass)
               want.nextPc = refPc + 8 + 4 * 32'(signed'(instr.br.offset));
         default: ;
      endcase
   end

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         refPc    <= '0;
         refFlags <= '0;
         for (int i = 0; i < 64; i++)
            refMem[i] <= 32'h7fff_ffc0 + i;
      end
      else
      begin
         refPc    <= want.nextPc;
         refFlags <= want.flags;
         if (want.regWrite)
            refRegs[instr.dp.rd] <= want.regVal;
         if (want.memWrite)
            refMem[want.adr[7:2]] <= want.data;
      end
   end

   // Data memory, combinational read
   assign readData = dmem[dataAdr[7:2]];

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 64; i++)
            dmem[i] <= 32'h7fff_ffc0 + i;         // Upper words sit near 2^31
      end
      else if (memWrite)
         dmem[dataAdr[7:2]] <= writeData;
   end

   always @(posedge clk)
   begin
      #2;
      instr = imem[pc[9:2]];                       // Fetch after the PC settles
   end

   pcMatches: assert property (@(posedge clk) pc == refPc)
      else reportMismatch("pc", $sampled(pc), $sampled(refPc));
   memWriteMatches: assert property (@(posedge clk) disable iff (reset)
      memWrite == want.memWrite)
      else reportMismatch("memWrite", $sampled(memWrite), $sampled(want.memWrite));
   adrMatches: assert property (@(posedge clk) disable iff (reset)
      want.memWrite |-> dataAdr == want.adr)
      else reportMismatch("dataAdr", $sampled(dataAdr), $sampled(want.adr));
   dataMatches: assert property (@(posedge clk) disable iff (reset)
      want.memWrite |-> writeData == want.data)
      else reportMismatch("writeData", $sampled(writeData), $sampled(want.data));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      int cycles;
      reset = 1'b0;
      rng   = 32'hfb04;
      buildProgram();
      instr = imem[0];
      #1;
      reset = 1'b1;                                // Async clear of PC and flags
      repeat (5) @(posedge clk);
      #2;
      reset  = 1'b0;
      cycles = 0;
      while (pc !== 32'(endIdx * 4) && cycles < maxCycles)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (pc !== 32'(endIdx * 4))
      begin
         $display("Timeout: program end not reached within %0d cycles", maxCycles);
         failRun();
      end
      else
      begin
         repeat (2) @(posedge clk);                // Let the final loop be checked
         #1;
         $display("Verification passed");
         $finish;
      end
   end

endmodule
